// File: logic/life_pkg.sv
// shared geometry, serial timing, character codes and state encodings
// for the 8x8 life machine; compile this package before any other source
`default_nettype none

package life_pkg;

  localparam int BOARD_W     = 8;
  localparam int BOARD_H     = 8;
  localparam int LOG_W       = 3;
  localparam int LOG_H       = 3;
  localparam int BOARD_CELLS = BOARD_W * BOARD_H;

  typedef logic [LOG_H+LOG_W-1:0] cell_index_t;  // row in upper bits, column in lower

  // long-period starting board, bit i is cell i
  localparam logic [BOARD_CELLS-1:0] INIT_PATTERN =
    64'b1100000111010000100010100100011001111110100110011101110110010111;

  localparam int CLKS_PER_BIT  = 16;
  localparam int AUTO_INTERVAL = 20000;  // cycles between auto-run steps

  localparam logic [7:0] CHAR_ALIVE    = 8'h4F;  // 'O'
  localparam logic [7:0] CHAR_DEAD     = 8'h20;
  localparam logic [7:0] CHAR_CR       = 8'h0D;
  localparam logic [7:0] CHAR_LF       = 8'h0A;
  localparam logic [7:0] CHAR_ESC      = 8'h1B;
  localparam logic [7:0] CHAR_LBRACKET = 8'h5B;
  localparam logic [7:0] CHAR_SEMI     = 8'h3B;
  localparam logic [7:0] CHAR_H        = 8'h48;

  localparam logic [7:0] CMD_RANDOM = 8'h30;  // '0'
  localparam logic [7:0] CMD_STEP   = 8'h31;  // '1'
  localparam logic [7:0] CMD_TOGGLE = 8'h20;  // space

  typedef enum logic [1:0] {OP_LOAD_INIT, OP_RANDOM, OP_STEP} board_op_e;

  typedef enum logic [1:0] {ST_WAIT_FIRST, ST_IDLE, ST_ENGINE, ST_PRINT} ctrl_state_e;

  typedef enum logic [2:0] {PR_IDLE, PR_HOME, PR_CELL, PR_EOL, PR_WAIT} print_state_e;

endpackage

`default_nettype wire

// File: logic/board_bus_if.sv
// board bus shared by the controller, the board engine and the frame printer
// carries the operation handshake, the print handshake and the cell read port
`timescale 1ns/1ps
`default_nettype none

interface board_bus_if;
  import life_pkg::*;

  logic        op_start;
  board_op_e   op;
  logic        op_done;
  logic        print_start;
  logic        print_done;
  cell_index_t rd_index;
  logic        rd_cell;  // combinational read of the live board

  modport engine  (input op_start, op, rd_index, output op_done, rd_cell);
  modport control (input op_done, print_done, output op_start, op, print_start);
  modport printer (input print_start, rd_cell, output print_done, rd_index);
endinterface

`default_nettype wire

// File: logic/uart_rx.sv
// serial receiver, 8N1 at CLKS_PER_BIT clocks per bit
// the received byte is held on a valid/ready output until accepted
// and a newer byte overwrites one that is still held
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  logic       clk,
  input  logic       boot_reset,
  input  logic       rxd,
  output logic [7:0] rx_data,
  output logic       rx_valid,
  input  logic       rx_ready
);
  import life_pkg::*;

  typedef logic [$clog2(CLKS_PER_BIT)-1:0] baud_cnt_t;

  logic       rxd_meta;
  logic       rxd_sync;
  logic       busy;
  baud_cnt_t  clk_cnt;
  logic [3:0] bit_cnt;    // start bit is slot 0, stop bit is slot 9
  logic [7:0] shift_reg;

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      busy     <= 1'b0;
      clk_cnt  <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      if (rx_valid && rx_ready)
        rx_valid <= 1'b0;
      if (!busy) begin
        if (!rxd_sync) begin          // falling edge of start bit
          busy    <= 1'b1;
          clk_cnt <= baud_cnt_t'(CLKS_PER_BIT / 2);  // first wrap lands mid start bit
          bit_cnt <= '0;
        end
      end else if (clk_cnt == baud_cnt_t'(CLKS_PER_BIT - 1)) begin
        clk_cnt <= '0;
        bit_cnt <= bit_cnt + 4'd1;
        if (bit_cnt == 4'd0) begin
          if (rxd_sync)
            busy <= 1'b0;             // glitch, not a real start bit
        end else if (bit_cnt == 4'd9) begin
          busy <= 1'b0;
          if (rxd_sync) begin         // good stop bit
            rx_data  <= shift_reg;
            rx_valid <= 1'b1;
          end
        end else begin
          shift_reg <= {rxd_sync, shift_reg[7:1]};  // lsb first
        end
      end else begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/uart_tx.sv
// serial transmitter, 8N1 at CLKS_PER_BIT clocks per bit
// accepts a byte on valid/ready only while the shifter is idle
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  logic       clk,
  input  logic       boot_reset,
  input  logic [7:0] tx_data,
  input  logic       tx_valid,
  output logic       tx_ready,
  output logic       txd
);
  import life_pkg::*;

  typedef logic [$clog2(CLKS_PER_BIT)-1:0] baud_cnt_t;

  logic       busy;
  baud_cnt_t  clk_cnt;
  logic [3:0] bit_cnt;    // bits already shifted after the start bit
  logic [8:0] shift_reg;  // data bits then stop bit

  assign tx_ready = !busy;

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
      txd     <= 1'b1;  // line idles high
    end else if (!busy) begin
      if (tx_valid) begin
        busy      <= 1'b1;
        txd       <= 1'b0;  // start bit
        shift_reg <= {1'b1, tx_data};
        clk_cnt   <= '0;
        bit_cnt   <= '0;
      end
    end else if (clk_cnt == baud_cnt_t'(CLKS_PER_BIT - 1)) begin
      clk_cnt <= '0;
      if (bit_cnt == 4'd9) begin
        busy <= 1'b0;       // stop bit done
      end else begin
        txd       <= shift_reg[0];
        shift_reg <= {1'b1, shift_reg[8:1]};
        bit_cnt   <= bit_cnt + 4'd1;
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: logic/lfsr_rng.sv
// free-running random bit source for board randomization
// 16-bit Galois LFSR with taps 16,14,13,11
`timescale 1ns/1ps
`default_nettype none

module lfsr_rng (
  input  logic clk,
  input  logic boot_reset,
  output logic random_bit
);

  logic [15:0] lfsr;

  assign random_bit = lfsr[0];

  always_ff @(posedge clk) begin
    if (boot_reset)
      lfsr <= 16'hACE1;  // any nonzero seed
    else
      lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
  end

endmodule

`default_nettype wire

// File: logic/board_engine.sv
// holds the live board and a shadow board and runs the board operations
// load and randomize write one cell per cycle; a step visits the eight
// wrapped neighbours of each cell, writes the rule result to the shadow
// board, then commits the shadow board in one cycle
`timescale 1ns/1ps
`default_nettype none

module board_engine (
  input  logic        clk,
  input  logic        boot_reset,
  input  logic        random_bit,
  board_bus_if.engine bus
);
  import life_pkg::*;

  logic [BOARD_CELLS-1:0] live;
  logic [BOARD_CELLS-1:0] shadow;
  logic             busy;
  logic             commit;
  board_op_e        op_r;
  board_op_e        cur_op;
  cell_index_t      index;
  logic [3:0]       nb_sel;    // 0..7 neighbours, 8 applies the rule
  logic [3:0]       nb_count;
  logic [LOG_H-1:0] d_row;
  logic [LOG_W-1:0] d_col;
  cell_index_t      nb_index;
  logic             last_cell;
  logic             next_alive;

  assign bus.rd_cell = live[bus.rd_index];
  assign cur_op      = busy ? op_r : bus.op;  // start cycle already does work
  assign last_cell   = (index == cell_index_t'(BOARD_CELLS - 1));

  // neighbour offsets, all ones means minus one
  always_comb begin
    case (nb_sel)
      4'd0:    begin d_row = '1;          d_col = '1;          end
      4'd1:    begin d_row = '1;          d_col = '0;          end
      4'd2:    begin d_row = '1;          d_col = LOG_W'(1);   end
      4'd3:    begin d_row = '0;          d_col = '1;          end
      4'd4:    begin d_row = '0;          d_col = LOG_W'(1);   end
      4'd5:    begin d_row = LOG_H'(1);   d_col = '1;          end
      4'd6:    begin d_row = LOG_H'(1);   d_col = '0;          end
      default: begin d_row = LOG_H'(1);   d_col = LOG_W'(1);   end
    endcase
  end

  // 3-bit sums wrap around the torus
  assign nb_index   = {index[LOG_W +: LOG_H] + d_row, index[LOG_W-1:0] + d_col};
  assign next_alive = (nb_count == 4'd3) || (live[index] && (nb_count == 4'd2));

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      busy        <= 1'b0;
      commit      <= 1'b0;
      op_r        <= OP_LOAD_INIT;
      index       <= '0;
      nb_sel      <= '0;
      nb_count    <= '0;
      bus.op_done <= 1'b0;
    end else begin
      bus.op_done <= 1'b0;
      if (commit) begin
        live        <= shadow;
        commit      <= 1'b0;
        bus.op_done <= 1'b1;
      end else if (busy || bus.op_start) begin
        if (!busy) begin
          busy <= 1'b1;
          op_r <= bus.op;
        end
        case (cur_op)
          OP_LOAD_INIT, OP_RANDOM: begin
            live[index] <= (cur_op == OP_RANDOM) ? random_bit : INIT_PATTERN[index];
            index       <= index + 1'b1;
            if (last_cell) begin
              busy        <= 1'b0;
              bus.op_done <= 1'b1;
            end
          end
          OP_STEP: begin
            if (nb_sel != 4'd8) begin
              nb_count <= nb_count + {3'b000, live[nb_index]};
              nb_sel   <= nb_sel + 4'd1;
            end else begin
              shadow[index] <= next_alive;
              nb_sel        <= '0;
              nb_count      <= '0;
              index         <= index + 1'b1;
              if (last_cell) begin
                busy   <= 1'b0;
                commit <= 1'b1;  // swap boards next cycle
              end
            end
          end
          default: busy <= 1'b0;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/frame_printer.sv
// prints the live board as one ANSI frame on the transmit handshake
// cursor home first, then eight rows of cells with CR LF between rows
// print_done pulses once the last cell byte has been taken
`timescale 1ns/1ps
`default_nettype none

module frame_printer (
  input  logic         clk,
  input  logic         boot_reset,
  board_bus_if.printer bus,
  output logic [7:0]   tx_data,
  output logic         tx_valid,
  input  logic         tx_ready
);
  import life_pkg::*;

  print_state_e     state;
  print_state_e     sent;      // kind of byte waiting in PR_WAIT
  logic [1:0]       home_cnt;
  logic             eol_lf;    // CR sent, LF next
  logic [LOG_H-1:0] row;
  logic [LOG_W-1:0] col;

  assign bus.rd_index = {row, col};

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      state          <= PR_IDLE;
      sent           <= PR_IDLE;
      tx_valid       <= 1'b0;
      bus.print_done <= 1'b0;
      home_cnt       <= '0;
      eol_lf         <= 1'b0;
      row            <= '0;
      col            <= '0;
    end else begin
      bus.print_done <= 1'b0;
      case (state)
        PR_IDLE: begin
          if (bus.print_start) begin
            home_cnt <= '0;
            eol_lf   <= 1'b0;
            row      <= '0;
            col      <= '0;
            state    <= PR_HOME;
          end
        end
        PR_HOME: begin
          case (home_cnt)
            2'd0:    tx_data <= CHAR_ESC;
            2'd1:    tx_data <= CHAR_LBRACKET;
            2'd2:    tx_data <= CHAR_SEMI;
            default: tx_data <= CHAR_H;
          endcase
          tx_valid <= 1'b1;
          sent     <= PR_HOME;
          state    <= PR_WAIT;
        end
        PR_CELL: begin
          tx_data  <= bus.rd_cell ? CHAR_ALIVE : CHAR_DEAD;
          tx_valid <= 1'b1;
          sent     <= PR_CELL;
          state    <= PR_WAIT;
        end
        PR_EOL: begin
          tx_data  <= eol_lf ? CHAR_LF : CHAR_CR;
          tx_valid <= 1'b1;
          sent     <= PR_EOL;
          state    <= PR_WAIT;
        end
        PR_WAIT: begin
          if (tx_valid && tx_ready) begin  // stalls here while the transmitter is busy
            tx_valid <= 1'b0;
            case (sent)
              PR_HOME: begin
                home_cnt <= home_cnt + 2'd1;
                state    <= (home_cnt == 2'd3) ? PR_CELL : PR_HOME;
              end
              PR_EOL: begin
                eol_lf <= !eol_lf;
                if (eol_lf) begin
                  row   <= row + 1'b1;
                  state <= PR_CELL;
                end else begin
                  state <= PR_EOL;
                end
              end
              default: begin
                col <= col + 1'b1;  // wraps to 0 at row end
                if (col != LOG_W'(BOARD_W - 1)) begin
                  state <= PR_CELL;
                end else if (row != LOG_H'(BOARD_H - 1)) begin
                  state <= PR_EOL;
                end else begin
                  state          <= PR_IDLE;
                  bus.print_done <= 1'b1;
                end
              end
            endcase
          end
        end
        default: state <= PR_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/life_control.sv
// command decoder and sequencer for the life machine
// takes a byte only while idle, starts the engine, then the printer
// and runs the auto-run interval timer
`timescale 1ns/1ps
`default_nettype none

module life_control (
  input  logic         clk,
  input  logic         boot_reset,
  input  logic [7:0]   rx_data,
  input  logic         rx_valid,
  output logic         rx_ready,
  board_bus_if.control bus
);
  import life_pkg::*;

  typedef logic [$clog2(AUTO_INTERVAL)-1:0] timer_t;

  ctrl_state_e state;
  logic        running;  // auto-run on
  timer_t      timer;
  logic        rx_fire;
  logic        timer_done;

  assign rx_fire    = rx_valid && rx_ready;
  assign timer_done = running && (timer == timer_t'(AUTO_INTERVAL - 1));

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      state           <= ST_WAIT_FIRST;
      running         <= 1'b0;
      timer           <= '0;
      rx_ready        <= 1'b0;
      bus.op          <= OP_LOAD_INIT;
      bus.op_start    <= 1'b0;
      bus.print_start <= 1'b0;
    end else begin
      bus.op_start    <= 1'b0;
      bus.print_start <= 1'b0;
      case (state)
        ST_WAIT_FIRST: begin
          if (rx_fire) begin         // any byte loads the starting pattern
            rx_ready     <= 1'b0;
            bus.op       <= OP_LOAD_INIT;
            bus.op_start <= 1'b1;
            state        <= ST_ENGINE;
          end else begin
            rx_ready <= 1'b1;
          end
        end
        ST_IDLE: begin
          if (rx_fire) begin
            rx_ready <= 1'b0;
            case (rx_data)
              CMD_RANDOM: begin
                bus.op       <= OP_RANDOM;
                bus.op_start <= 1'b1;
                state        <= ST_ENGINE;
              end
              CMD_STEP: begin
                if (!running) begin
                  bus.op       <= OP_STEP;
                  bus.op_start <= 1'b1;
                  state        <= ST_ENGINE;
                end else begin
                  running <= 1'b0;   // step key only stops auto-run
                  timer   <= '0;
                end
              end
              CMD_TOGGLE: begin
                running <= !running;
                timer   <= '0;
              end
              default: ;             // other bytes are dropped
            endcase
          end else if (timer_done) begin
            timer        <= '0;
            rx_ready     <= 1'b0;
            bus.op       <= OP_STEP;
            bus.op_start <= 1'b1;
            state        <= ST_ENGINE;
          end else begin
            rx_ready <= 1'b1;
            if (running)
              timer <= timer + 1'b1;
          end
        end
        ST_ENGINE: begin
          if (bus.op_done) begin
            bus.print_start <= 1'b1;
            state           <= ST_PRINT;
          end
        end
        default: begin               // ST_PRINT
          if (bus.print_done)
            state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/life_top.sv
// top level of the serial life machine
// receiver feeds the controller, the printer feeds the transmitter
`timescale 1ns/1ps
`default_nettype none

module life_top (
  input  logic clk,
  input  logic boot_reset,
  input  logic rxd,
  output logic txd
);

  logic [7:0] rx_data;
  logic       rx_valid;
  logic       rx_ready;
  logic [7:0] tx_data;
  logic       tx_valid;
  logic       tx_ready;
  logic       random_bit;

  board_bus_if bus ();

  uart_rx u_uart_rx (
    .clk        (clk),
    .boot_reset (boot_reset),
    .rxd        (rxd),
    .rx_data    (rx_data),
    .rx_valid   (rx_valid),
    .rx_ready   (rx_ready)
  );

  uart_tx u_uart_tx (
    .clk        (clk),
    .boot_reset (boot_reset),
    .tx_data    (tx_data),
    .tx_valid   (tx_valid),
    .tx_ready   (tx_ready),
    .txd        (txd)
  );

  lfsr_rng u_lfsr_rng (
    .clk        (clk),
    .boot_reset (boot_reset),
    .random_bit (random_bit)
  );

  board_engine u_board_engine (
    .clk        (clk),
    .boot_reset (boot_reset),
    .random_bit (random_bit),
    .bus        (bus.engine)
  );

  frame_printer u_frame_printer (
    .clk        (clk),
    .boot_reset (boot_reset),
    .bus        (bus.printer),
    .tx_data    (tx_data),
    .tx_valid   (tx_valid),
    .tx_ready   (tx_ready)
  );

  life_control u_life_control (
    .clk        (clk),
    .boot_reset (boot_reset),
    .rx_data    (rx_data),
    .rx_valid   (rx_valid),
    .rx_ready   (rx_ready),
    .bus        (bus.control)
  );

endmodule

`default_nettype wire

// File: dv/tb_serial.sv
// testbench serial port: sends bytes on rxd and decodes txd
// send_byte drives one 8N1 frame, received bytes collect in a queue
// read with byte_count and pop_byte
`timescale 1ns/1ps
`default_nettype none

module tb_serial (
  input  logic clk,
  output logic rxd,
  input  logic txd,
  output int   stop_errors
);
  import life_pkg::*;

  logic [7:0] captured[$];

  initial begin
    rxd = 1'b1;  // idle line
    stop_errors = 0;
  end

  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    int k;
    frame = {1'b1, b, 1'b0};  // stop, data, start
    for (k = 0; k < 10; k++) begin
      @(posedge clk);
      rxd <= frame[k];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  function automatic int byte_count();
    return captured.size();
  endfunction

  function automatic logic [7:0] pop_byte();
    return captured.pop_front();
  endfunction

  // decode txd, sampling near mid-bit on the falling clock edge
  initial begin : capture
    logic [7:0] b;
    int k;
    forever begin
      @(negedge clk);
      if (txd === 1'b0) begin
        repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
        for (k = 0; k < 8; k++) begin
          repeat (CLKS_PER_BIT) @(negedge clk);
          b[k] = txd;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        if (txd !== 1'b1) begin
          stop_errors = stop_errors + 1;
          $display("serial capture found no stop bit at %0t", $time);
        end
        captured.push_back(b);
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/life_tb.sv
// testbench for the serial life machine
// a table of command bytes and expected frame kinds is applied in a loop
// each frame is parsed and checked against a toroidal life model
`timescale 1ns/1ps
`default_nettype none

module life_tb;
  import life_pkg::*;

  localparam int FRAME_BYTES  = 82;
  localparam int FRAME_CYCLES = FRAME_BYTES * 10 * CLKS_PER_BIT;
  localparam int FRAME_WIN    = FRAME_CYCLES + 2000;
  localparam int AUTO_WIN     = 2 * (AUTO_INTERVAL + FRAME_WIN);  // two auto frames
  localparam int QUIET_CYCLES = 2000;

  // expected result kinds
  localparam int K_NONE = 0;
  localparam int K_INIT = 1;
  localparam int K_STEP = 2;
  localparam int K_ANY  = 3;
  localparam int K_AUTO = 4;

  localparam int NUM_STEPS = 9;
  localparam logic [7:0] STEP_CMD [NUM_STEPS] = '{8'h61, CMD_STEP, CMD_STEP, CMD_STEP, 8'h00,
                                                  CMD_RANDOM, CMD_STEP, CMD_TOGGLE, CMD_STEP};
  localparam bit STEP_RAND [NUM_STEPS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1,
                                           1'b0, 1'b0, 1'b0, 1'b0};
  localparam int STEP_KIND [NUM_STEPS] = '{K_INIT, K_STEP, K_STEP, K_STEP, K_NONE,
                                           K_ANY, K_STEP, K_AUTO, K_NONE};
  localparam int STEP_WINDOW [NUM_STEPS] = '{FRAME_WIN, FRAME_WIN, FRAME_WIN, FRAME_WIN,
                                             2 * FRAME_CYCLES, FRAME_WIN, FRAME_WIN,
                                             AUTO_WIN, 2 * AUTO_INTERVAL};
  string step_name [NUM_STEPS] = '{"first byte loads pattern", "step 1", "step 2", "step 3",
                                   "ignored byte", "randomize", "step after random",
                                   "auto-run two frames", "step stops auto-run"};

  logic        clk;
  logic        boot_reset;
  logic        rxd;
  logic        txd;
  int          stop_errors;
  int          errors;
  int          cycle_count;
  int          timeout_limit;
  logic [63:0] model;  // last board seen in a frame

  life_top u_dut (
    .clk        (clk),
    .boot_reset (boot_reset),
    .rxd        (rxd),
    .txd        (txd)
  );

  tb_serial u_ser (
    .clk         (clk),
    .rxd         (rxd),
    .txd         (txd),
    .stop_errors (stop_errors)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
      $display("timeout, run still going after %0d cycles", timeout_limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic report_value(input string sig, input logic [63:0] exp, input logic [63:0] got);
    errors++;
    $display("ERROR t=%0t %s expected %h got %h", $time, sig, exp, got);
  endtask

  // one generation on the 8x8 torus with cell index row * width + column
  function automatic logic [63:0] next_gen(input logic [63:0] b);
    logic [63:0] n;
    int r, c, dr, dc, cnt;
    n = '0;
    for (r = 0; r < BOARD_H; r++) begin
      for (c = 0; c < BOARD_W; c++) begin
        cnt = 0;
        for (dr = -1; dr <= 1; dr++)
          for (dc = -1; dc <= 1; dc++)
            if ((dr != 0 || dc != 0) &&
                b[((r + dr + BOARD_H) % BOARD_H) * BOARD_W + (c + dc + BOARD_W) % BOARD_W])
              cnt++;
        n[r * BOARD_W + c] = (cnt == 3) || (b[r * BOARD_W + c] && cnt == 2);
      end
    end
    return n;
  endfunction

  function automatic logic [7:0] home_char(input int k);
    case (k)
      0:       return CHAR_ESC;
      1:       return CHAR_LBRACKET;
      2:       return CHAR_SEMI;
      default: return CHAR_H;
    endcase
  endfunction

  // waits for a whole frame, then checks its layout and extracts the board
  task automatic get_frame(input int window, output logic [63:0] board, output bit ok);
    logic [7:0] fb [FRAME_BYTES];
    int waited, k, pos, r, c;
    waited = 0;
    ok = 1'b1;
    board = '0;
    while (u_ser.byte_count() < FRAME_BYTES && waited < window) begin
      @(negedge clk);
      waited++;
    end
    if (u_ser.byte_count() < FRAME_BYTES) begin
      errors++;
      $display("frame incomplete, %0d of %0d bytes after %0d cycles",
               u_ser.byte_count(), FRAME_BYTES, waited);
      ok = 1'b0;
      return;
    end
    for (k = 0; k < FRAME_BYTES; k++)
      fb[k] = u_ser.pop_byte();
    for (k = 0; k < 4; k++)
      if (fb[k] !== home_char(k)) begin
        report_value("home_byte", 64'(home_char(k)), 64'(fb[k]));
        ok = 1'b0;
      end
    pos = 4;
    for (r = 0; r < BOARD_H; r++) begin
      for (c = 0; c < BOARD_W; c++) begin
        if (fb[pos] == CHAR_ALIVE) begin
          board[r * BOARD_W + c] = 1'b1;
        end else if (fb[pos] != CHAR_DEAD) begin
          report_value("cell_char", 64'(CHAR_DEAD), 64'(fb[pos]));
          ok = 1'b0;
        end
        pos++;
      end
      if (r != BOARD_H - 1) begin  // row end
        if (fb[pos] !== CHAR_CR) begin
          report_value("row_cr", 64'(CHAR_CR), 64'(fb[pos]));
          ok = 1'b0;
        end
        if (fb[pos + 1] !== CHAR_LF) begin
          report_value("row_lf", 64'(CHAR_LF), 64'(fb[pos + 1]));
          ok = 1'b0;
        end
        pos += 2;
      end
    end
  endtask

  task automatic check_quiet();
    int k;
    bit seen;
    seen = 1'b0;
    for (k = 0; k < QUIET_CYCLES; k++) begin
      @(negedge clk);
      if (!seen && (txd !== 1'b1 || u_ser.byte_count() != 0)) begin
        seen = 1'b1;
        report_value("txd", 64'd1, 64'(txd));
      end
    end
  endtask

  task automatic run_step(input int i);
    logic [7:0]  cmd;
    logic [63:0] board;
    logic [63:0] exp_board;
    bit          ok;
    int          f;
    cmd = STEP_CMD[i];
    if (STEP_RAND[i]) begin
      cmd = 8'($urandom);
      while (cmd == CMD_RANDOM || cmd == CMD_STEP || cmd == CMD_TOGGLE)
        cmd = 8'($urandom);
    end
    repeat ($urandom_range(200, 0)) @(posedge clk);  // idle gap
    u_ser.send_byte(cmd);
    case (STEP_KIND[i])
      K_NONE: begin
        repeat (STEP_WINDOW[i]) @(negedge clk);
        if (u_ser.byte_count() != 0) begin
          report_value("captured_bytes", 64'd0, 64'(u_ser.byte_count()));
          while (u_ser.byte_count() != 0)
            void'(u_ser.pop_byte());
        end
      end
      K_AUTO: begin
        for (f = 0; f < 2; f++) begin
          get_frame(STEP_WINDOW[i] / 2, board, ok);
          exp_board = next_gen(model);
          if (ok && board !== exp_board)
            report_value("frame_board", exp_board, board);
          model = board;
        end
      end
      default: begin
        get_frame(STEP_WINDOW[i], board, ok);
        if (STEP_KIND[i] != K_ANY) begin  // a random board only has to be well formed
          exp_board = (STEP_KIND[i] == K_INIT) ? INIT_PATTERN : next_gen(model);
          if (ok && board !== exp_board)
            report_value("frame_board", exp_board, board);
        end
        model = board;
      end
    endcase
  endtask

  initial begin : main
    int i;
    int start_errors;
    int failed;
    errors = 0;
    failed = 0;
    cycle_count = 0;
    model = '0;
    boot_reset = 1'b1;
    void'($urandom(47740));
    timeout_limit = 10 + QUIET_CYCLES + 20 * FRAME_CYCLES;
    for (i = 0; i < NUM_STEPS; i++)
      timeout_limit += STEP_WINDOW[i];
    repeat (10) @(posedge clk);
    boot_reset <= 1'b0;

    check_quiet();
    if (errors != 0)
      failed++;
    $display("test 0 quiet after reset: %s", (errors == 0) ? "ok" : "failed");
    for (i = 0; i < NUM_STEPS; i++) begin
      start_errors = errors;
      run_step(i);
      if (errors != start_errors)
        failed++;
      $display("test %0d %s: %s", i + 1, step_name[i], (errors == start_errors) ? "ok" : "failed");
    end
    errors += stop_errors;

    $display("summary: %0d tests, %0d failed, %0d errors", NUM_STEPS + 1, failed, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
logic/life_pkg.sv
logic/board_bus_if.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/lfsr_rng.sv
logic/board_engine.sv
logic/frame_printer.sv
logic/life_control.sv
logic/life_top.sv
dv/tb_serial.sv
dv/life_tb.sv

// File: Makefile
# Verilator build and run for the serial life machine testbench

SRCS := $(shell grep -v '^+' list.f)
BIN  := obj_dir/Vlife_tb

.PHONY: all run clean

all: $(BIN)

$(BIN): list.f $(SRCS)
	verilator --binary --timing -j 0 --top-module life_tb -f list.f

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
